//--- verilog.f
design/decode_pkg.sv
design/inst_queue.sv
design/imm_gen.sv
design/inst_decode.sv
design/fault_ctrl.sv
design/decode_top.sv
dv/decode_chk.sv
dv/decode_tb.sv

//--- dv/decode_tb.sv
`timescale 1ns/100ps
`default_nettype none

module decode_tb;

	localparam int N_BURST = 36;
	localparam int N_STALL = 40;
	// Reset, the fixed tests, one burst at full rate and one at up to four cycles per word.
	localparam int CYCLE_LIMIT = 8 + 100 + (N_BURST + 10) + 4 * (N_STALL + 10) + 200;

	logic i_clock;
	logic i_reset;
	logic i_inst_strobe;
	logic [31:0] i_inst;
	logic [decode_pkg::xlen-1:0] i_pc;
	logic i_execute_busy;
	logic i_fault_clear;
	wire o_queue_full;
	wire o_overflow;
	wire o_fault;
	wire o_valid;
	wire [decode_pkg::xlen-1:0] o_out_pc;
	wire [decode_pkg::reg_index_w-1:0] o_rd;
	wire [decode_pkg::reg_index_w-1:0] o_rs1;
	wire [decode_pkg::reg_index_w-1:0] o_rs2;
	wire [decode_pkg::xlen-1:0] o_out_imm;
	wire decode_pkg::alu_op_t o_alu_op;
	wire decode_pkg::operand_sel_t o_operand1;
	wire decode_pkg::operand_sel_t o_operand2;
	wire o_mem_read;
	wire o_mem_write;
	wire decode_pkg::mem_width_t o_mem_width;
	wire o_mem_signed;
	wire o_jump;
	wire o_branch;
	wire o_writes_rd;

	logic [31:0] lfsr_state;
	logic [decode_pkg::xlen-1:0] next_pc;
	logic [63:0] expected_q[$]; // Program counter and word of every record still owed.
	int cycle_count;

	decode_top #(.QUEUE_DEPTH(4)) DUT (.*);

	task automatic stop_run();
		$display("STATUS: FAIL");
		$fatal(1, "Simulation stopped after the first error.");
	endtask

	task automatic check_word(input string name, input logic [decode_pkg::xlen-1:0] exp,
		input logic [decode_pkg::xlen-1:0] act);
		if (exp !== act) begin
			$display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_index(input string name, input logic [decode_pkg::reg_index_w-1:0] exp,
		input logic [decode_pkg::reg_index_w-1:0] act);
		if (exp !== act) begin
			$display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_alu(input string name, input decode_pkg::alu_op_t exp,
		input decode_pkg::alu_op_t act);
		if (exp !== act) begin
			$display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_sel(input string name, input decode_pkg::operand_sel_t exp,
		input decode_pkg::operand_sel_t act);
		if (exp !== act) begin
			$display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_width(input string name, input decode_pkg::mem_width_t exp,
		input decode_pkg::mem_width_t act);
		if (exp !== act) begin
			$display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
			stop_run();
		end
	endtask

	function automatic int unsigned assertion_failures();
		return DUT.u_decode.u_decode_chk.failures + DUT.u_queue.u_queue_chk.failures;
	endfunction

	function automatic logic lfsr_bit();
		logic out;
		out = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out)
			lfsr_state = lfsr_state ^ 32'hD000_0001;
		return out;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsr_bit()};
		return v;
	endfunction

	function automatic logic [31:0] sign_extend(input logic [31:0] v, input int bits);
		return 32'($signed(v << (32 - bits)) >>> (32 - bits));
	endfunction

	// Builds a legal RV32I word of the given opcode class with random fields.
	function automatic logic [31:0] make_word(input int kind);
		logic [31:0] r;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [2:0] f3;
		logic [6:0] f7;
		rd = rand_bits(5);
		rs1 = rand_bits(5);
		rs2 = rand_bits(5);
		f3 = rand_bits(3);
		r = rand_bits(20);
		f7 = {1'b0, lfsr_bit(), 5'b0};
		case (kind)
			0: return {r[19:0], rd, decode_pkg::OPC_LUI};
			1: return {r[19:0], rd, decode_pkg::OPC_AUIPC};
			2: return {r[19:0], rd, decode_pkg::OPC_JAL};
			3: return {r[11:0], rs1, 3'b000, rd, decode_pkg::OPC_JALR};
			4: begin
				if (f3[2:1] == 2'b01)
					f3[2] = 1'b1; // Codes 2 and 3 are reserved for branches.
				return {r[6:0], rs2, rs1, f3, r[11:7], decode_pkg::OPC_BRANCH};
			end
			5: begin
				if (f3 == 3'd3 || f3 == 3'd6 || f3 == 3'd7)
					f3 = 3'd2;
				return {r[11:0], rs1, f3, rd, decode_pkg::OPC_LOAD};
			end
			6: begin
				f3 = (f3[1:0] == 2'b11) ? 3'd2 : {1'b0, f3[1:0]};
				return {r[6:0], rs2, rs1, f3, r[11:7], decode_pkg::OPC_STORE};
			end
			7: begin
				if (f3 == 3'd1)
					return {7'b0, rs2, rs1, f3, rd, decode_pkg::OPC_OP_IMM};
				if (f3 == 3'd5)
					return {f7, rs2, rs1, f3, rd, decode_pkg::OPC_OP_IMM};
				return {r[11:0], rs1, f3, rd, decode_pkg::OPC_OP_IMM};
			end
			default: begin
				if (f3 != 3'd0 && f3 != 3'd5)
					f7 = 7'b0;
				return {f7, rs2, rs1, f3, rd, decode_pkg::OPC_OP};
			end
		endcase
	endfunction

	function automatic decode_pkg::alu_op_t arith_expect(input logic [2:0] f3, input logic alt);
		case (f3)
			3'd0: return alt ? decode_pkg::ALU_SUB : decode_pkg::ALU_ADD;
			3'd1: return decode_pkg::ALU_SLL;
			3'd2: return decode_pkg::ALU_SLT;
			3'd3: return decode_pkg::ALU_SLTU;
			3'd4: return decode_pkg::ALU_XOR;
			3'd5: return alt ? decode_pkg::ALU_SRA : decode_pkg::ALU_SRL;
			3'd6: return decode_pkg::ALU_OR;
			default: return decode_pkg::ALU_AND;
		endcase
	endfunction

	// The reference decoder works out the record from the encoding and compares it.
	task automatic check_record(input logic [31:0] pc, input logic [31:0] w);
		logic [2:0] f3;
		logic [31:0] e_imm;
		decode_pkg::alu_op_t e_alu;
		decode_pkg::operand_sel_t e_op1;
		decode_pkg::operand_sel_t e_op2;
		decode_pkg::mem_width_t e_width;
		logic e_signed;
		logic e_read;
		logic e_write;
		logic e_jump;
		logic e_branch;
		logic e_wr;
		f3 = w[14:12];
		e_imm = sign_extend(w[31:20], 12);
		e_alu = decode_pkg::ALU_ADD;
		e_op1 = decode_pkg::SEL_RS1;
		e_op2 = decode_pkg::SEL_IMM;
		e_read = 1'b0;
		e_write = 1'b0;
		e_jump = 1'b0;
		e_branch = 1'b0;
		e_wr = 1'b1;
		case (f3[1:0])
			2'b00: e_width = decode_pkg::MEM_BYTE;
			2'b01: e_width = decode_pkg::MEM_HALF;
			default: e_width = decode_pkg::MEM_WORD;
		endcase
		e_signed = (f3 != 3'd4 && f3 != 3'd5); // Only LBU and LHU are unsigned.
		case (w[6:0])
			decode_pkg::OPC_LUI: begin
				e_imm = {w[31:12], 12'b0};
				e_op1 = decode_pkg::SEL_ZERO;
			end
			decode_pkg::OPC_AUIPC: begin
				e_imm = {w[31:12], 12'b0};
				e_op1 = decode_pkg::SEL_PC;
			end
			decode_pkg::OPC_JAL: begin
				e_imm = sign_extend({w[31], w[19:12], w[20], w[30:21], 1'b0}, 21);
				e_op1 = decode_pkg::SEL_PC;
				e_jump = 1'b1;
			end
			decode_pkg::OPC_JALR: e_jump = 1'b1;
			decode_pkg::OPC_BRANCH: begin
				e_imm = sign_extend({w[31], w[7], w[30:25], w[11:8], 1'b0}, 13);
				e_op2 = decode_pkg::SEL_RS2;
				e_branch = 1'b1;
				e_wr = 1'b0;
				e_alu = decode_pkg::alu_op_t'(f3 == 3'd0 ? 10 : f3 == 3'd1 ? 11 : f3 + 8);
			end
			decode_pkg::OPC_LOAD: e_read = 1'b1;
			decode_pkg::OPC_STORE: begin
				e_imm = sign_extend({w[31:25], w[11:7]}, 12);
				e_write = 1'b1;
				e_wr = 1'b0;
			end
			decode_pkg::OPC_OP_IMM: begin
				if (f3 == 3'd1 || f3 == 3'd5)
					e_imm = {27'b0, w[24:20]}; // Shifts carry a plain shift amount.
				e_alu = arith_expect(f3, f3 == 3'd5 && w[30]);
			end
			decode_pkg::OPC_OP: begin
				e_imm = '0;
				e_op2 = decode_pkg::SEL_RS2;
				e_alu = arith_expect(f3, w[30]);
			end
			default: begin
				$display("Reference decoder was handed a word it does not support: %h", w);
				stop_run();
			end
		endcase
		check_word("o_out_pc", pc, o_out_pc);
		check_index("o_rd", w[11:7], o_rd);
		check_index("o_rs1", w[19:15], o_rs1);
		check_index("o_rs2", w[24:20], o_rs2);
		check_word("o_out_imm", e_imm, o_out_imm);
		check_alu("o_alu_op", e_alu, o_alu_op);
		check_sel("o_operand1", e_op1, o_operand1);
		check_sel("o_operand2", e_op2, o_operand2);
		check_bit("o_mem_read", e_read, o_mem_read);
		check_bit("o_mem_write", e_write, o_mem_write);
		if (e_read || e_write)
			check_width("o_mem_width", e_width, o_mem_width);
		if (e_read)
			check_bit("o_mem_signed", e_signed, o_mem_signed);
		check_bit("o_jump", e_jump, o_jump);
		check_bit("o_branch", e_branch, o_branch);
		check_bit("o_writes_rd", e_wr, o_writes_rd);
	endtask

	task automatic next_cycle();
		@(posedge i_clock);
		#1;
	endtask

	task automatic strobe_word(input logic [31:0] w, input logic expected);
		i_inst_strobe = 1'b1;
		i_inst = w;
		i_pc = next_pc;
		if (expected)
			expected_q.push_back({next_pc, w});
		next_pc = next_pc + 4;
	endtask

	task automatic wait_drain();
		while (expected_q.size() != 0)
			next_cycle();
	endtask

	task automatic test_reset_and_latency();
		check_bit("o_valid", 1'b0, o_valid);
		check_bit("o_fault", 1'b0, o_fault);
		check_bit("o_overflow", 1'b0, o_overflow);
		check_bit("o_queue_full", 1'b0, o_queue_full);
		strobe_word({12'hffd, 5'd6, 3'b000, 5'd5, decode_pkg::OPC_OP_IMM}, 1'b1);
		next_cycle();
		i_inst_strobe = 1'b0;
		check_bit("o_valid", 1'b0, o_valid);
		next_cycle();
		check_bit("o_valid", 1'b1, o_valid);
		wait_drain();
	endtask

	task automatic test_back_to_back();
		for (int i = 0; i < N_BURST; i++) begin
			strobe_word(make_word(i % 9), 1'b1);
			next_cycle();
		end
		i_inst_strobe = 1'b0;
		wait_drain();
	endtask

	task automatic test_random_stall();
		int sent;
		sent = 0;
		while (sent < N_STALL || expected_q.size() != 0) begin
			i_execute_busy = lfsr_bit();
			if (sent < N_STALL && !o_queue_full) begin
				strobe_word(make_word(rand_bits(4) % 9), 1'b1);
				sent++;
			end
			else
				i_inst_strobe = 1'b0;
			next_cycle();
		end
		i_execute_busy = 1'b0;
		i_inst_strobe = 1'b0;
	endtask

	task automatic test_overflow();
		i_execute_busy = 1'b1;
		strobe_word(make_word(7), 1'b1);
		next_cycle();
		i_inst_strobe = 1'b0;
		while (!o_valid)
			next_cycle();
		for (int i = 0; i < 4; i++) begin
			strobe_word(make_word(i), 1'b1);
			next_cycle();
		end
		i_inst_strobe = 1'b0;
		check_bit("o_queue_full", 1'b1, o_queue_full);
		check_bit("o_overflow", 1'b0, o_overflow);
		strobe_word(make_word(8), 1'b0); // Dropped by the full queue.
		next_cycle();
		i_inst_strobe = 1'b0;
		check_bit("o_overflow", 1'b1, o_overflow);
		i_execute_busy = 1'b0;
		wait_drain();
		repeat (6) next_cycle();
		check_bit("o_queue_full", 1'b0, o_queue_full);
	endtask

	task automatic test_fault_and_clear();
		strobe_word(32'h0010_0073, 1'b0); // EBREAK from the SYSTEM opcode.
		next_cycle();
		strobe_word(make_word(8), 1'b0);
		next_cycle();
		strobe_word(make_word(5), 1'b0);
		next_cycle();
		i_inst_strobe = 1'b0;
		while (!o_fault)
			next_cycle();
		check_bit("o_valid", 1'b0, o_valid);
		repeat (6) next_cycle();
		check_bit("o_fault", 1'b1, o_fault);
		i_fault_clear = 1'b1;
		next_cycle();
		i_fault_clear = 1'b0;
		check_bit("o_fault", 1'b0, o_fault);
		repeat (4) next_cycle();
		strobe_word(make_word(6), 1'b1);
		next_cycle();
		i_inst_strobe = 1'b0;
		wait_drain();
		repeat (4) next_cycle();
		check_bit("o_fault", 1'b0, o_fault);
	endtask

	// Any valid record is checked against the oldest one owed and retired when consumed.
	always @(negedge i_clock) begin
		if (!i_reset && o_valid) begin
			if (expected_q.size() == 0) begin
				$display("At %0t a record was presented with no instruction outstanding.", $time);
				stop_run();
			end
			else begin
				check_record(expected_q[0][63:32], expected_q[0][31:0]);
				if (!i_execute_busy)
					void'(expected_q.pop_front());
			end
		end
	end

	// A failed bound assertion ends the run at the next falling edge.
	always @(negedge i_clock) begin
		if (assertion_failures() != 0) begin
			$display("At %0t a bound assertion on the decoder or queue failed.", $time);
			stop_run();
		end
	end

	always @(posedge i_clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("Timeout: the run went past %0d cycles.", CYCLE_LIMIT);
			stop_run();
		end
	end

	initial begin
		i_clock = 1'b0;
		forever #4 i_clock = ~i_clock;
	end

	initial begin
		i_reset = 1'b1;
		i_inst_strobe = 1'b0;
		i_inst = '0;
		i_pc = '0;
		i_execute_busy = 1'b0;
		i_fault_clear = 1'b0;
		lfsr_state = 32'h2bd0_29f6;
		next_pc = 32'h0000_1000;
		cycle_count = 0;
		repeat (8) @(posedge i_clock);
		#1;
		i_reset = 1'b0;
		test_reset_and_latency();
		test_back_to_back();
		test_random_stall();
		test_overflow();
		test_fault_and_clear();
		if (assertion_failures() != 0) begin
			$display("A bound assertion on the decoder or queue failed.");
			stop_run();
		end
		else begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- dv/decode_chk.sv
`timescale 1ns/100ps
`default_nettype none

module decode_chk #(
	parameter int REC_W = 97
) (
	input wire i_clock,
	input wire i_reset,
	input wire i_valid,
	input wire i_busy,
	input wire i_run,
	input wire i_pop,
	input wire i_empty,
	input wire [REC_W-1:0] i_record
);

	int unsigned failures = 0; // Number of assertion failures so far.

	// A stalled record keeps every field and stays valid.
	assert property (@(posedge i_clock) disable iff (i_reset)
		i_valid && i_busy |=> i_valid && $stable(i_record))
		else begin
			failures++;
			$error("Decoded record changed while execute was busy.");
		end

	assert property (@(posedge i_clock) disable iff (i_reset) i_pop |-> !i_empty)
		else begin
			failures++;
			$error("Pop requested from an empty instruction queue.");
		end

	assert property (@(posedge i_clock) disable iff (i_reset) !i_run |-> !i_valid)
		else begin
			failures++;
			$error("Valid record presented while the fault controller halts.");
		end

endmodule

bind inst_decode decode_chk u_decode_chk (
	.i_clock(i_clock), .i_reset(i_reset), .i_valid(o_valid), .i_busy(i_execute_busy),
	.i_run(i_run), .i_pop(o_pop), .i_empty(i_empty),
	.i_record({o_out_pc, o_rd, o_rs1, o_rs2, o_out_imm, o_alu_op, o_operand1, o_operand2,
		o_mem_read, o_mem_write, o_mem_width, o_mem_signed, o_jump, o_branch, o_writes_rd})
);

// The queue side only checks its own pop against its empty flag.
bind inst_queue decode_chk u_queue_chk (
	.i_clock(i_clock), .i_reset(i_reset), .i_valid(1'b0), .i_busy(1'b0),
	.i_run(1'b1), .i_pop(i_pop), .i_empty(o_empty), .i_record('0)
);

`default_nettype wire

//--- design/decode_top.sv
`timescale 1ns/100ps
`default_nettype none

module decode_top #(
	parameter int QUEUE_DEPTH = 4
) (
	input wire i_clock,
	input wire i_reset,
	input wire i_inst_strobe,
	input wire [31:0] i_inst,
	input wire [decode_pkg::xlen-1:0] i_pc,
	input wire i_execute_busy,
	input wire i_fault_clear,
	output wire o_queue_full,
	output wire o_overflow,
	output wire o_fault,
	output wire o_valid,
	output wire [decode_pkg::xlen-1:0] o_out_pc,
	output wire [decode_pkg::reg_index_w-1:0] o_rd,
	output wire [decode_pkg::reg_index_w-1:0] o_rs1,
	output wire [decode_pkg::reg_index_w-1:0] o_rs2,
	output wire [decode_pkg::xlen-1:0] o_out_imm,
	output wire decode_pkg::alu_op_t o_alu_op,
	output wire decode_pkg::operand_sel_t o_operand1,
	output wire decode_pkg::operand_sel_t o_operand2,
	output wire o_mem_read,
	output wire o_mem_write,
	output wire decode_pkg::mem_width_t o_mem_width,
	output wire o_mem_signed,
	output wire o_jump,
	output wire o_branch,
	output wire o_writes_rd
);

	wire [decode_pkg::xlen-1:0] q_pc;
	wire [31:0] q_inst;
	wire q_empty;
	wire q_pop;
	wire [decode_pkg::xlen-1:0] imm;
	wire decode_pkg::imm_fmt_t imm_fmt;
	wire run;
	wire flush;
	wire fault_event;

	inst_queue #(.DEPTH(QUEUE_DEPTH)) u_queue (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_push(i_inst_strobe), .i_pc(i_pc), .i_inst(i_inst),
		.i_pop(q_pop), .i_flush(flush),
		.o_pc(q_pc), .o_inst(q_inst), .o_empty(q_empty),
		.o_full(o_queue_full), .o_overflow(o_overflow)
	);

	imm_gen u_imm_gen (.i_inst(q_inst), .o_imm(imm), .o_fmt(imm_fmt));

	fault_ctrl u_fault_ctrl (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_fault_event(fault_event), .i_fault_clear(i_fault_clear),
		.o_run(run), .o_flush(flush), .o_fault(o_fault)
	);

	inst_decode u_decode (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_pc(q_pc), .i_inst(q_inst), .i_empty(q_empty), .o_pop(q_pop),
		.i_imm(imm), .i_fmt(imm_fmt), .i_run(run), .i_execute_busy(i_execute_busy),
		.o_fault_event(fault_event), .o_valid(o_valid), .o_out_pc(o_out_pc),
		.o_rd(o_rd), .o_rs1(o_rs1), .o_rs2(o_rs2), .o_out_imm(o_out_imm),
		.o_alu_op(o_alu_op), .o_operand1(o_operand1), .o_operand2(o_operand2),
		.o_mem_read(o_mem_read), .o_mem_write(o_mem_write),
		.o_mem_width(o_mem_width), .o_mem_signed(o_mem_signed),
		.o_jump(o_jump), .o_branch(o_branch), .o_writes_rd(o_writes_rd)
	);

endmodule

`default_nettype wire

//--- design/fault_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module fault_ctrl (
	input wire i_clock,
	input wire i_reset,
	input wire i_fault_event,
	input wire i_fault_clear,
	output logic o_run,
	output logic o_flush,
	output logic o_fault
);

	typedef enum logic {
		RUN  = 1'b0,
		HALT = 1'b1
	} state_t;

	state_t state;
	state_t state_next;

	always_comb begin
		state_next = state;
		case (state)
			RUN:
				if (i_fault_event)
					state_next = HALT;
			HALT:
				if (i_fault_clear)
					state_next = RUN;
			default: state_next = RUN;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset)
			state <= RUN;
		else
			state <= state_next;
	end

	assign o_run = (state == RUN);
	assign o_fault = (state == HALT);

	// The queue empties on the same edge that returns the machine to RUN.
	assign o_flush = (state == HALT) && i_fault_clear;

endmodule

`default_nettype wire

//--- design/inst_decode.sv
`timescale 1ns/100ps
`default_nettype none

module inst_decode (
	input wire i_clock,
	input wire i_reset,
	input wire [decode_pkg::xlen-1:0] i_pc,
	input wire [31:0] i_inst,
	input wire i_empty,
	output logic o_pop,
	input wire [decode_pkg::xlen-1:0] i_imm,
	input wire decode_pkg::imm_fmt_t i_fmt,
	input wire i_run,
	input wire i_execute_busy,
	output logic o_fault_event,
	output logic o_valid,
	output logic [decode_pkg::xlen-1:0] o_out_pc,
	output logic [decode_pkg::reg_index_w-1:0] o_rd,
	output logic [decode_pkg::reg_index_w-1:0] o_rs1,
	output logic [decode_pkg::reg_index_w-1:0] o_rs2,
	output logic [decode_pkg::xlen-1:0] o_out_imm,
	output decode_pkg::alu_op_t o_alu_op,
	output decode_pkg::operand_sel_t o_operand1,
	output decode_pkg::operand_sel_t o_operand2,
	output logic o_mem_read,
	output logic o_mem_write,
	output decode_pkg::mem_width_t o_mem_width,
	output logic o_mem_signed,
	output logic o_jump,
	output logic o_branch,
	output logic o_writes_rd
);

	decode_pkg::opcode_t opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic take;
	logic consume;
	logic dec_ok;
	decode_pkg::alu_op_t alu_op;
	decode_pkg::operand_sel_t operand1;
	decode_pkg::operand_sel_t operand2;
	logic mem_read;
	logic mem_write;
	decode_pkg::mem_width_t mem_width;
	logic mem_signed;
	logic jump;
	logic branch;
	logic writes_rd;

	// Shared funct3 table of OP and OP_IMM; alt selects SUB and SRA.
	function automatic decode_pkg::alu_op_t arith_op(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: return alt ? decode_pkg::ALU_SUB : decode_pkg::ALU_ADD;
			3'b001: return decode_pkg::ALU_SLL;
			3'b010: return decode_pkg::ALU_SLT;
			3'b011: return decode_pkg::ALU_SLTU;
			3'b100: return decode_pkg::ALU_XOR;
			3'b101: return alt ? decode_pkg::ALU_SRA : decode_pkg::ALU_SRL;
			3'b110: return decode_pkg::ALU_OR;
			default: return decode_pkg::ALU_AND;
		endcase
	endfunction

	assign opcode = decode_pkg::opcode_t'(i_inst[6:0]);
	assign funct3 = i_inst[14:12];
	assign funct7 = i_inst[31:25];

	// The output register is free when empty or being consumed this cycle.
	assign consume = o_valid && !i_execute_busy;
	assign take = !i_empty && i_run && (!o_valid || !i_execute_busy);
	assign o_pop = take;
	assign o_fault_event = take && !dec_ok;

	always_comb begin
		dec_ok = 1'b1;
		alu_op = decode_pkg::ALU_ADD;
		operand1 = decode_pkg::SEL_RS1;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_width = decode_pkg::MEM_WORD;
		mem_signed = 1'b0;
		jump = 1'b0;
		branch = 1'b0;
		case (opcode)
			decode_pkg::OPC_LUI: operand1 = decode_pkg::SEL_ZERO;
			decode_pkg::OPC_AUIPC: operand1 = decode_pkg::SEL_PC;
			decode_pkg::OPC_JAL: begin
				operand1 = decode_pkg::SEL_PC; // Target is PC plus offset.
				jump = 1'b1;
			end
			decode_pkg::OPC_JALR: jump = 1'b1;
			decode_pkg::OPC_BRANCH: begin
				branch = 1'b1;
				case (funct3)
					3'b000: alu_op = decode_pkg::ALU_EQ;
					3'b001: alu_op = decode_pkg::ALU_NE;
					3'b100: alu_op = decode_pkg::ALU_LT;
					3'b101: alu_op = decode_pkg::ALU_GE;
					3'b110: alu_op = decode_pkg::ALU_LTU;
					3'b111: alu_op = decode_pkg::ALU_GEU;
					default: dec_ok = 1'b0;
				endcase
			end
			decode_pkg::OPC_LOAD: begin
				mem_read = 1'b1;
				mem_width = decode_pkg::mem_width_t'(funct3[1:0]);
				mem_signed = !funct3[2]; // LBU and LHU zero-extend.
				if (funct3[1:0] == 2'b11 || funct3 == 3'b110)
					dec_ok = 1'b0;
			end
			decode_pkg::OPC_STORE: begin
				mem_write = 1'b1;
				mem_width = decode_pkg::mem_width_t'(funct3[1:0]);
				if (funct3[2] || funct3[1:0] == 2'b11)
					dec_ok = 1'b0;
			end
			decode_pkg::OPC_OP_IMM: alu_op = arith_op(funct3, funct3 == 3'b101 && i_inst[30]);
			decode_pkg::OPC_OP: begin
				alu_op = arith_op(funct3, i_inst[30]);
				if (funct7 != 7'h00 && funct7 != 7'h20)
					dec_ok = 1'b0; // M extension lands here.
			end
			default: dec_ok = 1'b0;
		endcase
	end

	// Branches and register-register ops take rs2, everything else the immediate.
	assign operand2 = (i_fmt == decode_pkg::IMM_B || i_fmt == decode_pkg::IMM_NONE) ?
		decode_pkg::SEL_RS2 : decode_pkg::SEL_IMM;
	assign writes_rd = !(i_fmt == decode_pkg::IMM_S || i_fmt == decode_pkg::IMM_B);

	always_ff @(posedge i_clock) begin
		if (i_reset)
			o_valid <= 1'b0;
		else if (take)
			o_valid <= dec_ok; // A faulting word leaves no record.
		else if (consume)
			o_valid <= 1'b0;
	end

	always_ff @(posedge i_clock) begin
		if (take) begin
			o_out_pc <= i_pc;
			o_rd <= i_inst[11:7];
			o_rs1 <= i_inst[19:15];
			o_rs2 <= i_inst[24:20];
			o_out_imm <= i_imm;
			o_alu_op <= alu_op;
			o_operand1 <= operand1;
			o_operand2 <= operand2;
			o_mem_read <= mem_read;
			o_mem_write <= mem_write;
			o_mem_width <= mem_width;
			o_mem_signed <= mem_signed;
			o_jump <= jump;
			o_branch <= branch;
			o_writes_rd <= writes_rd;
		end
	end

endmodule

`default_nettype wire

//--- design/imm_gen.sv
`timescale 1ns/100ps
`default_nettype none

module imm_gen (
	input wire [31:0] i_inst,
	output logic [decode_pkg::xlen-1:0] o_imm,
	output decode_pkg::imm_fmt_t o_fmt
);

	decode_pkg::opcode_t opcode;
	logic is_shift_imm;
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;

	assign opcode = decode_pkg::opcode_t'(i_inst[6:0]);

	// SLLI, SRLI and SRAI carry a shift amount instead of a signed immediate.
	assign is_shift_imm = (opcode == decode_pkg::OPC_OP_IMM) && (i_inst[13:12] == 2'b01);

	assign imm_i = {{21{i_inst[31]}}, i_inst[30:20]};
	assign imm_s = {{21{i_inst[31]}}, i_inst[30:25], i_inst[11:7]};
	assign imm_b = {{20{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
	assign imm_u = {i_inst[31:12], 12'b0};
	assign imm_j = {{12{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

	always_comb begin
		case (opcode)
			decode_pkg::OPC_LUI,
			decode_pkg::OPC_AUIPC: o_fmt = decode_pkg::IMM_U;
			decode_pkg::OPC_JAL: o_fmt = decode_pkg::IMM_J;
			decode_pkg::OPC_JALR,
			decode_pkg::OPC_LOAD,
			decode_pkg::OPC_OP_IMM: o_fmt = decode_pkg::IMM_I;
			decode_pkg::OPC_STORE: o_fmt = decode_pkg::IMM_S;
			decode_pkg::OPC_BRANCH: o_fmt = decode_pkg::IMM_B;
			default: o_fmt = decode_pkg::IMM_NONE; // OP and everything unsupported.
		endcase
	end

	always_comb begin
		case (o_fmt)
			decode_pkg::IMM_I: o_imm = is_shift_imm ? {27'b0, i_inst[24:20]} : imm_i;
			decode_pkg::IMM_S: o_imm = imm_s;
			decode_pkg::IMM_B: o_imm = imm_b;
			decode_pkg::IMM_U: o_imm = imm_u;
			decode_pkg::IMM_J: o_imm = imm_j;
			default: o_imm = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- design/inst_queue.sv
`timescale 1ns/100ps
`default_nettype none

module inst_queue #(
	parameter int DEPTH = 4
) (
	input wire i_clock,
	input wire i_reset,
	input wire i_push,
	input wire [decode_pkg::xlen-1:0] i_pc,
	input wire [31:0] i_inst,
	input wire i_pop,
	input wire i_flush,
	output logic [decode_pkg::xlen-1:0] o_pc,
	output logic [31:0] o_inst,
	output logic o_empty,
	output logic o_full,
	output logic o_overflow
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [decode_pkg::xlen-1:0] pc_mem [DEPTH];
	logic [31:0] inst_mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_push;
	logic do_pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1; // Wraps for any depth.
	endfunction

	assign o_empty = (count == '0);
	assign o_full = (count == CNT_W'(DEPTH));
	assign do_push = i_push && !o_full && !i_flush;
	assign do_pop = i_pop && !o_empty && !i_flush;

	// The head is visible without a read strobe.
	assign o_pc = pc_mem[rd_ptr];
	assign o_inst = inst_mem[rd_ptr];

	always_ff @(posedge i_clock) begin
		if (do_push) begin
			pc_mem[wr_ptr] <= i_pc;
			inst_mem[wr_ptr] <= i_inst;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			o_overflow <= 1'b0;
		end
		else begin
			if (i_flush) begin
				wr_ptr <= '0;
				rd_ptr <= '0;
				count <= '0;
			end
			else begin
				if (do_push)
					wr_ptr <= next_ptr(wr_ptr);
				if (do_pop)
					rd_ptr <= next_ptr(rd_ptr);
				if (do_push && !do_pop)
					count <= count + 1'b1;
				else if (do_pop && !do_push)
					count <= count - 1'b1;
			end
			if (i_push && o_full)
				o_overflow <= 1'b1; // Sticky until reset.
		end
	end

endmodule

`default_nettype wire

//--- design/decode_pkg.sv
`default_nettype none

package decode_pkg;

	parameter int xlen = 32; // Data and address width.
	parameter int reg_index_w = 5;

	// RV32I major opcodes handled by the decoder.
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011
	} opcode_t;

	typedef enum logic [2:0] {
		IMM_NONE = 3'd0,
		IMM_I    = 3'd1,
		IMM_S    = 3'd2,
		IMM_B    = 3'd3,
		IMM_U    = 3'd4,
		IMM_J    = 3'd5
	} imm_fmt_t;

	// The branch compares share the ALU operation field with arithmetic.
	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_SLL  = 4'd2,
		ALU_SLT  = 4'd3,
		ALU_SLTU = 4'd4,
		ALU_XOR  = 4'd5,
		ALU_SRL  = 4'd6,
		ALU_SRA  = 4'd7,
		ALU_OR   = 4'd8,
		ALU_AND  = 4'd9,
		ALU_EQ   = 4'd10,
		ALU_NE   = 4'd11,
		ALU_LT   = 4'd12,
		ALU_GE   = 4'd13,
		ALU_LTU  = 4'd14,
		ALU_GEU  = 4'd15
	} alu_op_t;

	typedef enum logic [2:0] {
		SEL_ZERO = 3'd0,
		SEL_RS1  = 3'd1,
		SEL_RS2  = 3'd2,
		SEL_PC   = 3'd3,
		SEL_IMM  = 3'd4
	} operand_sel_t;

	// Encoded like funct3[1:0] of loads and stores.
	typedef enum logic [1:0] {
		MEM_BYTE = 2'd0,
		MEM_HALF = 2'd1,
		MEM_WORD = 2'd2
	} mem_width_t;

endpackage

`default_nettype wire
